//--- hdl/boot_rom.mem
// Boot ROM words in hex, eight per line, word index 0 first
4ff8 0400 41f9 0031 0000 7000 1080 4e71
0c28 0001 0002 66f8 41f9 0030 0000 3028
03fe 0240 0800 67f4 43f9 0004 0000 303c
07ff 22d8 51c8 fffc 4eb9 0004 0000 6000
fffe 2f3c 4344 2d69 2f3c 4150 5020 4e75
7201 e389 d241 3601 c6fc 0a5a 4843 9643
1e3c 00c3 b23c 0017 4e73 ff35 ff36 ff37
ff38 ff39 ff3a ff3b ff3c ff3d ff3e ff3f

//--- compile.f
hdl/cdi_bus_pkg.sv
hdl/chip_select_if.sv
hdl/bus_decode.sv
hdl/boot_rom.sv
hdl/irq4_arbiter.sv
hdl/bus_response.sv
hdl/cdi_bus_glue.sv
test/cdi_bus_glue_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := cdi_bus_glue_tb
FILELIST  := compile.f
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only -Wall --timing
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- test/cdi_bus_glue_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cdi_bus_glue_tb;
    import cdi_bus_pkg::*;

    // Tests take about 1300 cycles
    localparam int CYCLE_LIMIT = 5000;
    localparam int WAIT_LIMIT  = 8;

    localparam logic [23:0] ERR_PROBES [13] = '{
        24'h07fffe, 24'h080000, 24'h1ffffe, 24'h200000, 24'h500000, 24'hcffffe, 24'hd00000,
        24'he80000, 24'heffffe, 24'hf00000, 24'hf00070, 24'hf10000, 24'hfffffe
    };
    localparam logic [23:0] RESP_PROBES [8] = '{
        24'h310000, 24'h300010, 24'he00100, 24'h320020, 24'h001000, 24'hd00000, 24'he40000,
        24'h380000
    };

    logic       clk30;
    logic       reset;
    logic       slave_reset;
    bus_addr_t  addr;
    logic       as;
    logic       uds;
    logic       lds;
    logic       iack4;
    bus_word_t  data_in;
    logic       bus_ack;
    logic       bus_err;
    logic       mpeg_ram_enabled;
    logic       cd_img_mounted;
    logic       config_auto_play;
    logic       audio_cd_in_tray;
    logic       rom_enabled;
    logic [7:0] slave_data;
    logic [7:0] nvram_data;
    bus_word_t  cdic_data;
    bus_word_t  mpeg_data;
    bus_word_t  video_data;
    logic       cdic_ack;
    logic       mpeg_ack;
    logic       nvram_ack;
    logic       video_ack;
    logic       slave_dtack;
    logic       cdic_intreq;
    logic       mpeg_intreq;
    logic       irq4;
    logic       cdic_intack;
    logic       mpeg_intack;
    logic       slave_irq;
    logic       cs_video;
    logic       cs_dvc_ram;
    logic       cs_dvc_rom;
    logic       cs_mpeg;
    logic       cs_cdic;
    logic       cs_slave;
    logic       cs_nvram;
    logic       cs_rom;

    logic [7:0] sel_seen;
    bus_word_t  rom_model [ROM_DEPTH];
    logic       slave_flag;
    int         error_count = 0;
    int         check_count = 0;
    int         cycle_count = 0;

    cdi_bus_glue u_cdi_bus_glue (.*);

    assign sel_seen = {cs_video, cs_dvc_ram, cs_dvc_rom, cs_mpeg,
                       cs_cdic, cs_slave, cs_nvram, cs_rom};

    initial begin
        clk30 = 1'b0;
        forever #10 clk30 = ~clk30;
    end

    always @(posedge clk30) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the tests did not finish", CYCLE_LIMIT);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    function automatic logic expected_rom_enabled();
        return cd_img_mounted && config_auto_play && !audio_cd_in_tray && !slave_flag;
    endfunction

    // Bit order matches sel_seen
    function automatic logic [7:0] expected_selects(logic [23:0] a, logic strobe);
        logic [7:0] s;
        s[7] = (a <= VIDEO_LOW_END) || (a >= VIDEO_HIGH_START && a < 24'h800000);
        s[6] = (a >= DVC_RAM_BASE && a < DVC_RAM_BASE + 24'h100000)
               || (a >= DVC_RAM_MPEG_BASE && a < DVC_RAM_MPEG_BASE + 24'h080000);
        s[5] = a >= DVC_ROM_BASE && a < DVC_ROM_BASE + 24'h040000;
        s[4] = a >= MPEG_BASE && a < MPEG_BASE + 24'h040000;
        s[3] = a[23:16] == CDIC_PAGE;
        s[2] = a[23:16] == SLAVE_PAGE;
        s[1] = a[23:16] == NVRAM_PAGE;
        s[0] = a >= ROM_BASE && a <= ROM_LAST && expected_rom_enabled();
        return strobe ? s : 8'h00;
    endfunction

    function automatic logic expected_err(logic [23:0] a, logic active);
        logic region;
        region = (a >= ERR_AREA1_START && a < ERR_AREA1_END)
                 || (a >= ERR_AREA2_START && a < ERR_AREA2_END)
                 || (a >= ERR_ABOVE_ROM)
                 || (a >= ROM_BASE && !expected_rom_enabled())
                 || (a >= DVC_RAM_MPEG_BASE && a < DVC_RAM_MPEG_BASE + 24'h080000
                     && !mpeg_ram_enabled);
        return region && active;
    endfunction

    // Ack in bit 16, data below, in priority order
    function automatic logic [16:0] expected_response(logic [7:0] s, logic slave_ack);
        if (s[2]) return {slave_ack, slave_data, slave_data};
        if (s[3]) return {cdic_ack, cdic_data};
        if (s[4]) return {mpeg_ack, mpeg_data};
        if (s[1]) return {nvram_ack, nvram_data, nvram_data};
        if (s[7] || s[6] || s[5]) return {video_ack, video_data};
        return {1'b1, 16'h0000};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("ERR %s got %h expected %h at cycle %0d", name, got, exp, cycle_count);
        end
    endtask

    // Drive on the rising edge, return at the falling edge with outputs settled
    task automatic drive_bus(input logic [23:0] a, input logic strobe, input logic [1:0] ds);
        @(posedge clk30);
        addr <= a[23:1];
        as   <= strobe;
        uds  <= ds[1];
        lds  <= ds[0];
        @(negedge clk30);
    endtask

    task automatic wait_for_ack(output int latency);
        latency = 0;
        while (!bus_ack && latency < WAIT_LIMIT) begin
            @(negedge clk30);
            latency++;
        end
        if (!bus_ack) begin
            error_count++;
            $display("No bus_ack within %0d cycles", WAIT_LIMIT);
        end
    endtask

    task automatic wait_for_irq4(output int latency);
        latency = 0;
        while (!irq4 && latency < WAIT_LIMIT) begin
            @(negedge clk30);
            latency++;
        end
        if (!irq4) begin
            error_count++;
            $display("irq4 was not raised within %0d cycles", WAIT_LIMIT);
        end
    endtask

    task automatic decode_test();
        logic [23:0] a;
        for (int i = 0; i < 300; i++) begin
            a = 24'($urandom) & 24'hfffffe;
            case ($urandom % 3)
                0: a[23:20] = 4'hd + 4'($urandom % 3);
                1: a[23:16] = CDIC_PAGE + 8'($urandom % 3);
                default: ;
            endcase
            if ($urandom % 5 == 0)
                a = ROM_BASE + 24'(2 * ($urandom % 64));
            drive_bus(a, 1'b1, 2'b11);
            check_value("chip selects", sel_seen, expected_selects(a, 1'b1));
            check_value("bus_err", bus_err, expected_err(a, 1'b1));
            drive_bus(a, 1'b0, 2'b11);
            check_value("chip selects", sel_seen, 8'h00);
            check_value("bus_err", bus_err, 1'b0);
        end
    endtask

    task automatic bus_error_test();
        for (int r = 0; r < 2; r++) begin
            for (int m = 0; m < 2; m++) begin
                @(posedge clk30);
                config_auto_play <= r[0];
                mpeg_ram_enabled <= m[0];
                foreach (ERR_PROBES[p]) begin
                    for (int d = 0; d < 4; d++) begin
                        drive_bus(ERR_PROBES[p], 1'b1, d[1:0]);
                        check_value("bus_err", bus_err, expected_err(ERR_PROBES[p], d != 0));
                    end
                end
            end
        end
        drive_bus(24'h0, 1'b0, 2'b00);
    endtask

    task automatic response_test();
        logic [16:0] exp;
        @(posedge clk30);
        config_auto_play <= 1'b1;
        mpeg_ram_enabled <= 1'b1;
        slave_data       <= 8'h5a;
        nvram_data       <= 8'hc3;
        cdic_data        <= 16'hcd1c;
        mpeg_data        <= 16'h3e60;
        video_data       <= 16'h7d0e;
        foreach (RESP_PROBES[p]) begin
            for (int k = 0; k < 2; k++) begin
                @(posedge clk30);
                cdic_ack  <= k[0];
                mpeg_ack  <= !k[0];
                nvram_ack <= k[0];
                video_ack <= !k[0];
                drive_bus(RESP_PROBES[p], 1'b1, 2'b11);
                exp = expected_response(expected_selects(RESP_PROBES[p], 1'b1), 1'b0);
                check_value("data_in", data_in, exp[15:0]);
                check_value("bus_ack", bus_ack, exp[16]);
                drive_bus(RESP_PROBES[p], 1'b0, 2'b00);
            end
        end
    endtask

    task automatic boot_rom_test();
        int latency;
        check_value("rom_enabled", rom_enabled, 1'b1);
        for (int i = 0; i <= int'((ROM_LAST - ROM_BASE) / 2); i++) begin
            drive_bus(ROM_BASE + 24'(2 * i), 1'b1, 2'b11);
            check_value("cs_rom", cs_rom, 1'b1);
            wait_for_ack(latency);
            check_value("rom ack latency", latency, 1);
            check_value("data_in", data_in, rom_model[i]);
            drive_bus(24'h0, 1'b0, 2'b00);
        end
        // Held select gives an ack on every other cycle
        drive_bus(ROM_BASE + 24'h10, 1'b1, 2'b11);
        for (int k = 0; k < 6; k++) begin
            check_value("bus_ack", bus_ack, k % 2);
            if (k % 2 == 1)
                check_value("data_in", data_in, rom_model[8]);
            @(negedge clk30);
        end
        drive_bus(24'h0, 1'b0, 2'b00);
        @(posedge clk30);
        slave_reset <= 1'b1;
        @(posedge clk30);
        slave_reset <= 1'b0;
        slave_flag = 1'b1;
        drive_bus(ROM_BASE, 1'b1, 2'b01);
        check_value("rom_enabled", rom_enabled, 1'b0);
        check_value("cs_rom", cs_rom, 1'b0);
        check_value("bus_err", bus_err, 1'b1);
        drive_bus(24'h0, 1'b0, 2'b00);
        @(posedge clk30);
        reset <= 1'b1;
        @(posedge clk30);
        reset <= 1'b0;
        slave_flag = 1'b0;
        drive_bus(ROM_BASE + 24'h2, 1'b1, 2'b11);
        check_value("bus_err", bus_err, 1'b0);
        wait_for_ack(latency);
        check_value("data_in", data_in, rom_model[1]);
        drive_bus(24'h0, 1'b0, 2'b00);
    endtask

    task automatic slave_test();
        int latency;
        int pulses;
        int delay;
        for (int n = 0; n < 3; n++) begin
            delay = 1 + int'($urandom % 4);
            @(posedge clk30);
            slave_data <= 8'($urandom);
            drive_bus({SLAVE_PAGE, 16'(2 * n)}, 1'b1, 2'b01);
            pulses = int'(slave_irq);
            for (int k = 0; k < delay; k++) begin
                check_value("bus_ack", bus_ack, 1'b0);
                @(negedge clk30);
                pulses += int'(slave_irq);
            end
            @(posedge clk30);
            slave_dtack <= 1'b1;
            @(negedge clk30);
            pulses += int'(slave_irq);
            wait_for_ack(latency);
            check_value("slave ack latency", latency, 0);
            check_value("data_in", data_in, {slave_data, slave_data});
            // A held dtack level must not ack again
            @(negedge clk30);
            pulses += int'(slave_irq);
            check_value("bus_ack", bus_ack, 1'b0);
            @(posedge clk30);
            as          <= 1'b0;
            slave_dtack <= 1'b0;
            @(negedge clk30);
            check_value("slave_irq pulses", pulses, 1);
        end
    endtask

    task automatic vector_fetch(input logic to_mpeg);
        @(posedge clk30);
        iack4 <= 1'b1;
        @(negedge clk30);
        check_value("cdic_intack", cdic_intack, !to_mpeg);
        check_value("mpeg_intack", mpeg_intack, to_mpeg);
        check_value("data_in", data_in, to_mpeg ? mpeg_data : cdic_data);
        check_value("bus_ack", bus_ack, 1'b1);
        @(posedge clk30);
        iack4 <= 1'b0;
    endtask

    task automatic irq_test();
        int latency;
        @(posedge clk30);
        cdic_intreq <= 1'b1;
        @(negedge clk30);
        wait_for_irq4(latency);
        check_value("irq4 latency", latency, 1);
        @(posedge clk30);
        mpeg_intreq <= 1'b1;
        repeat (3) begin
            @(negedge clk30);
            check_value("irq4", irq4, 1'b1);
        end
        vector_fetch(1'b0);
        @(posedge clk30);
        cdic_intreq <= 1'b0;
        @(negedge clk30);
        check_value("irq4", irq4, 1'b0);
        // Release takes a cycle, then MPEG takes over
        wait_for_irq4(latency);
        check_value("irq4 latency", latency, 2);
        vector_fetch(1'b1);
        @(posedge clk30);
        mpeg_intreq <= 1'b0;
        @(negedge clk30);
        check_value("irq4", irq4, 1'b0);
        repeat (2) @(negedge clk30);
        @(posedge clk30);
        cdic_intreq <= 1'b1;
        mpeg_intreq <= 1'b1;
        @(negedge clk30);
        wait_for_irq4(latency);
        check_value("irq4 latency", latency, 1);
        vector_fetch(1'b1);
        @(posedge clk30);
        mpeg_intreq <= 1'b0;
        @(negedge clk30);
        wait_for_irq4(latency);
        check_value("irq4 latency", latency, 2);
        vector_fetch(1'b0);
        @(posedge clk30);
        cdic_intreq <= 1'b0;
        @(negedge clk30);
        check_value("irq4", irq4, 1'b0);
    endtask

    initial begin
        reset            <= 1'b1;
        slave_reset      <= 1'b0;
        addr             <= '0;
        as               <= 1'b0;
        uds              <= 1'b0;
        lds              <= 1'b0;
        iack4            <= 1'b0;
        mpeg_ram_enabled <= 1'b1;
        cd_img_mounted   <= 1'b1;
        config_auto_play <= 1'b1;
        audio_cd_in_tray <= 1'b0;
        slave_data       <= '0;
        nvram_data       <= '0;
        cdic_data        <= '0;
        mpeg_data        <= '0;
        video_data       <= '0;
        cdic_ack         <= 1'b0;
        mpeg_ack         <= 1'b0;
        nvram_ack        <= 1'b0;
        video_ack        <= 1'b0;
        slave_dtack      <= 1'b0;
        cdic_intreq      <= 1'b0;
        mpeg_intreq      <= 1'b0;
        slave_flag = 1'b0;
        void'($urandom(32'hf13c5201));
        $readmemh(ROM_FILE, rom_model);
        repeat (10) @(posedge clk30);
        reset <= 1'b0;

        decode_test();
        bus_error_test();
        response_test();
        boot_rom_test();
        slave_test();
        irq_test();

        @(negedge clk30);
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/cdi_bus_glue.sv
`timescale 1ns/1ps
`default_nettype none

module cdi_bus_glue (
    input  logic                   clk30,
    input  logic                   reset,
    input  logic                   slave_reset,

    // CPU bus
    input  cdi_bus_pkg::bus_addr_t addr,
    input  logic                   as,
    input  logic                   uds,
    input  logic                   lds,
    input  logic                   iack4,
    output cdi_bus_pkg::bus_word_t data_in,
    output logic                   bus_ack,
    output logic                   bus_err,

    // Configuration
    input  logic                   mpeg_ram_enabled,
    input  logic                   cd_img_mounted,
    input  logic                   config_auto_play,
    input  logic                   audio_cd_in_tray,
    output logic                   rom_enabled,

    // Peripheral responses
    input  logic [7:0]             slave_data,
    input  logic [7:0]             nvram_data,
    input  cdi_bus_pkg::bus_word_t cdic_data,
    input  cdi_bus_pkg::bus_word_t mpeg_data,
    input  cdi_bus_pkg::bus_word_t video_data,
    input  logic                   cdic_ack,
    input  logic                   mpeg_ack,
    input  logic                   nvram_ack,
    input  logic                   video_ack,
    input  logic                   slave_dtack,

    // Interrupts
    input  logic                   cdic_intreq,
    input  logic                   mpeg_intreq,
    output logic                   irq4,
    output logic                   cdic_intack,
    output logic                   mpeg_intack,
    output logic                   slave_irq,

    // Chip selects
    output logic                   cs_video,
    output logic                   cs_dvc_ram,
    output logic                   cs_dvc_rom,
    output logic                   cs_mpeg,
    output logic                   cs_cdic,
    output logic                   cs_slave,
    output logic                   cs_nvram,
    output logic                   cs_rom
);
    import cdi_bus_pkg::*;

    logic      sys_reset;
    bus_word_t rom_data;
    logic      rom_ack;

    chip_select_if cs_bus ();

    // The slave can reset the whole machine through its port pin
    assign sys_reset = reset || slave_reset;

    bus_decode u_decode (
        .addr            (addr),
        .as              (as),
        .uds             (uds),
        .lds             (lds),
        .rom_enabled     (rom_enabled),
        .mpeg_ram_enabled(mpeg_ram_enabled),
        .cs              (cs_bus.decoder),
        .bus_err         (bus_err)
    );

    boot_rom u_boot_rom (
        .clk30           (clk30),
        .reset           (reset),
        .slave_reset     (slave_reset),
        .cd_img_mounted  (cd_img_mounted),
        .config_auto_play(config_auto_play),
        .audio_cd_in_tray(audio_cd_in_tray),
        .addr            (addr),
        .cs              (cs_bus.responder),
        .rom_enabled     (rom_enabled),
        .rom_data        (rom_data),
        .rom_ack         (rom_ack)
    );

    irq4_arbiter u_irq4_arbiter (
        .clk30      (clk30),
        .reset      (sys_reset),
        .cdic_intreq(cdic_intreq),
        .mpeg_intreq(mpeg_intreq),
        .iack4      (iack4),
        .irq4       (irq4),
        .cdic_intack(cdic_intack),
        .mpeg_intack(mpeg_intack)
    );

    bus_response u_response (
        .clk30      (clk30),
        .reset      (sys_reset),
        .cs         (cs_bus.responder),
        .slave_data (slave_data),
        .nvram_data (nvram_data),
        .cdic_data  (cdic_data),
        .mpeg_data  (mpeg_data),
        .video_data (video_data),
        .rom_data   (rom_data),
        .cdic_ack   (cdic_ack),
        .mpeg_ack   (mpeg_ack),
        .nvram_ack  (nvram_ack),
        .video_ack  (video_ack),
        .rom_ack    (rom_ack),
        .slave_dtack(slave_dtack),
        .cdic_intack(cdic_intack),
        .mpeg_intack(mpeg_intack),
        .data_in    (data_in),
        .bus_ack    (bus_ack),
        .slave_irq  (slave_irq)
    );

    assign cs_video   = cs_bus.video;
    assign cs_dvc_ram = cs_bus.dvc_ram;
    assign cs_dvc_rom = cs_bus.dvc_rom;
    assign cs_mpeg    = cs_bus.mpeg;
    assign cs_cdic    = cs_bus.cdic;
    assign cs_slave   = cs_bus.slave;
    assign cs_nvram   = cs_bus.nvram;
    assign cs_rom     = cs_bus.rom;

endmodule

`default_nettype wire

//--- hdl/bus_response.sv
`timescale 1ns/1ps
`default_nettype none

module bus_response (
    input  logic                   clk30,
    input  logic                   reset,
    chip_select_if.responder       cs,
    input  logic [7:0]             slave_data,
    input  logic [7:0]             nvram_data,
    input  cdi_bus_pkg::bus_word_t cdic_data,
    input  cdi_bus_pkg::bus_word_t mpeg_data,
    input  cdi_bus_pkg::bus_word_t video_data,
    input  cdi_bus_pkg::bus_word_t rom_data,
    input  logic                   cdic_ack,
    input  logic                   mpeg_ack,
    input  logic                   nvram_ack,
    input  logic                   video_ack,
    input  logic                   rom_ack,
    input  logic                   slave_dtack,
    input  logic                   cdic_intack,
    input  logic                   mpeg_intack,
    output cdi_bus_pkg::bus_word_t data_in,
    output logic                   bus_ack,
    output logic                   slave_irq
);
    import cdi_bus_pkg::*;

    logic slave_dtack_q;
    logic slave_sel_q;
    logic slave_ack;

    // History for the slave handshake edges
    always_ff @(posedge clk30) begin
        if (reset) begin
            slave_dtack_q <= 1'b0;
            slave_sel_q   <= 1'b0;
        end else begin
            slave_dtack_q <= slave_dtack;
            slave_sel_q   <= cs.slave;
        end
    end

    // The slave raises its ack level by port bit, so only the edge counts
    assign slave_ack = slave_dtack && !slave_dtack_q;

    // Wake the slave on the first cycle of each access
    assign slave_irq = cs.slave && !slave_sel_q;

    always_comb begin
        // Unmapped cycles finish immediately
        data_in = '0;
        bus_ack = 1'b1;

        case (cs.responder_sel)
            RESP_SLAVE: begin
                data_in = {slave_data, slave_data};
                bus_ack = slave_ack;
            end
            RESP_CDIC: begin
                data_in = cdic_data;
                bus_ack = cdic_ack;
            end
            RESP_MPEG: begin
                data_in = mpeg_data;
                bus_ack = mpeg_ack;
            end
            RESP_NVRAM: begin
                data_in = {nvram_data, nvram_data};
                bus_ack = nvram_ack;
            end
            RESP_VIDEO: begin
                data_in = video_data;
                bus_ack = video_ack;
            end
            RESP_ROM: begin
                data_in = rom_data;
                bus_ack = rom_ack;
            end
            default: begin
                data_in = '0;
                bus_ack = 1'b1;
            end
        endcase

        // Interrupt vector fetch overrides the address decode
        if (cdic_intack) begin
            data_in = cdic_data;
            bus_ack = 1'b1;
        end

        if (mpeg_intack) begin
            data_in = mpeg_data;
            bus_ack = 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hdl/irq4_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module irq4_arbiter (
    input  logic clk30,
    input  logic reset,
    input  logic cdic_intreq,
    input  logic mpeg_intreq,
    input  logic iack4,
    output logic irq4,
    output logic cdic_intack,
    output logic mpeg_intack
);
    import cdi_bus_pkg::*;

    irq_owner_e owner;

    // Set-reset latch of the level-4 line that the first requester keeps
    always_ff @(posedge clk30) begin
        if (reset) begin
            owner <= OWNER_IDLE;
        end else begin
            case (owner)
                OWNER_CDIC: begin
                    if (!cdic_intreq)
                        owner <= OWNER_IDLE;
                end
                OWNER_MPEG: begin
                    if (!mpeg_intreq)
                        owner <= OWNER_IDLE;
                end
                default: begin
                    // MPEG wins a tie
                    if (mpeg_intreq)
                        owner <= OWNER_MPEG;
                    else if (cdic_intreq)
                        owner <= OWNER_CDIC;
                end
            endcase
        end
    end

    assign irq4 = ((owner == OWNER_CDIC) && cdic_intreq)
                  || ((owner == OWNER_MPEG) && mpeg_intreq);

    // Vector fetch goes to whoever holds the line
    assign cdic_intack = iack4 && (owner == OWNER_CDIC);
    assign mpeg_intack = iack4 && (owner == OWNER_MPEG);

    a_intack_excl: assert property (
        @(posedge clk30) disable iff (reset) !(cdic_intack && mpeg_intack)
    );

endmodule

`default_nettype wire

//--- hdl/boot_rom.sv
`timescale 1ns/1ps
`default_nettype none

module boot_rom (
    input  logic                   clk30,
    input  logic                   reset,
    input  logic                   slave_reset,
    input  logic                   cd_img_mounted,
    input  logic                   config_auto_play,
    input  logic                   audio_cd_in_tray,
    input  cdi_bus_pkg::bus_addr_t addr,
    chip_select_if.responder       cs,
    output logic                   rom_enabled,
    output cdi_bus_pkg::bus_word_t rom_data,
    output logic                   rom_ack
);
    import cdi_bus_pkg::*;

    bus_word_t rom_mem [ROM_DEPTH];
    logic      last_reset_by_slave;

    initial begin
        $readmemh(ROM_FILE, rom_mem);
    end

    // Quitting to the shell goes through a slave reset, so remember it
    always_ff @(posedge clk30) begin
        if (reset) begin
            last_reset_by_slave <= 1'b0;
        end else if (slave_reset) begin
            last_reset_by_slave <= 1'b1;
        end
    end

    // Auto-play only for a mounted CD-i image after a clean reset
    assign rom_enabled = cd_img_mounted && config_auto_play && !audio_cd_in_tray
                         && !last_reset_by_slave;

    always_ff @(posedge clk30) begin
        rom_data <= rom_mem[addr[ROM_INDEX_W:1]];
    end

    // Ack drops for a cycle between words so the CPU sees a fresh edge
    always_ff @(posedge clk30) begin
        rom_ack <= !(reset || slave_reset) && cs.rom && !rom_ack;
    end

    a_ack_pulse: assert property (@(posedge clk30) rom_ack |=> !rom_ack);

endmodule

`default_nettype wire

//--- hdl/bus_decode.sv
`timescale 1ns/1ps
`default_nettype none

module bus_decode (
    input  cdi_bus_pkg::bus_addr_t addr,
    input  logic                   as,
    input  logic                   uds,
    input  logic                   lds,
    input  logic                   rom_enabled,
    input  logic                   mpeg_ram_enabled,
    chip_select_if.decoder         cs,
    output logic                   bus_err
);
    import cdi_bus_pkg::*;

    logic [ADDR_W-1:0] addr_byte;
    logic              mpeg_ram_window;
    logic              err_region;

    assign addr_byte = {addr, 1'b0};

    // The MPEG RAM window sits inside the cartridge RAM decode
    assign mpeg_ram_window = addr_byte[23:19] == DVC_RAM_MPEG_BASE[23:19];

    // Video chip owns RAM, but never the upper half of the map
    assign cs.video   = ((addr_byte <= VIDEO_LOW_END) || (addr_byte >= VIDEO_HIGH_START))
                        && !addr[23] && as;
    assign cs.dvc_ram = ((addr_byte[23:20] == DVC_RAM_BASE[23:20]) || mpeg_ram_window) && as;
    assign cs.dvc_rom = (addr_byte[23:18] == DVC_ROM_BASE[23:18]) && as;
    assign cs.mpeg    = (addr_byte[23:18] == MPEG_BASE[23:18]) && as;
    assign cs.cdic    = (addr_byte[23:16] == CDIC_PAGE) && as;
    assign cs.slave   = (addr_byte[23:16] == SLAVE_PAGE) && as;
    assign cs.nvram   = (addr_byte[23:16] == NVRAM_PAGE) && as;
    assign cs.rom     = (addr_byte >= ROM_BASE) && (addr_byte <= ROM_LAST)
                        && rom_enabled && as;

    // Responder priority for the read data path
    always_comb begin
        if (cs.slave) begin
            cs.responder_sel = RESP_SLAVE;
        end else if (cs.cdic) begin
            cs.responder_sel = RESP_CDIC;
        end else if (cs.mpeg) begin
            cs.responder_sel = RESP_MPEG;
        end else if (cs.nvram) begin
            cs.responder_sel = RESP_NVRAM;
        end else if (cs.video || cs.dvc_ram || cs.dvc_rom) begin
            cs.responder_sel = RESP_VIDEO;
        end else if (cs.rom) begin
            cs.responder_sel = RESP_ROM;
        end else begin
            cs.responder_sel = RESP_NONE;
        end
    end

    always_comb begin
        err_region = 1'b0;
        if (addr_byte >= ERR_AREA1_START && addr_byte < ERR_AREA1_END)
            err_region = 1'b1;
        if (addr_byte >= ERR_AREA2_START && addr_byte < ERR_AREA2_END)
            err_region = 1'b1;
        if (addr_byte >= ERR_ABOVE_ROM)
            err_region = 1'b1;
        // ROM area is unmapped when auto-play is off
        if (addr_byte >= ROM_BASE && !rom_enabled)
            err_region = 1'b1;
        // MPEG RAM stays locked until the cartridge opens it
        if (mpeg_ram_window && !mpeg_ram_enabled)
            err_region = 1'b1;
    end

    assign bus_err = err_region && as && (uds || lds);

    // Peripheral pages never overlap
    always_comb begin
        a_page_onehot: assert final ($onehot0({cs.cdic, cs.slave, cs.nvram}));
    end

endmodule

`default_nettype wire

//--- hdl/chip_select_if.sv
`timescale 1ns/1ps
`default_nettype none

interface chip_select_if;
    import cdi_bus_pkg::*;

    logic       video;
    logic       dvc_ram;
    logic       dvc_rom;
    logic       mpeg;
    logic       cdic;
    logic       slave;
    logic       nvram;
    logic       rom;
    responder_e responder_sel;

    modport decoder (
        output video, dvc_ram, dvc_rom, mpeg, cdic, slave, nvram, rom, responder_sel
    );

    modport responder (
        input video, dvc_ram, dvc_rom, mpeg, cdic, slave, nvram, rom, responder_sel
    );

endinterface

`default_nettype wire

//--- hdl/cdi_bus_pkg.sv
`default_nettype none

package cdi_bus_pkg;

    // Bus widths
    localparam int ADDR_W = 24;
    localparam int WORD_W = 16;

    // CPU word address without bit 0, which the data strobes select
    typedef logic [ADDR_W-1:1] bus_addr_t;
    typedef logic [WORD_W-1:0] bus_word_t;

    // Who answers the current bus cycle
    typedef enum logic [2:0] {
        RESP_NONE,
        RESP_SLAVE,
        RESP_CDIC,
        RESP_MPEG,
        RESP_NVRAM,
        RESP_VIDEO,
        RESP_ROM
    } responder_e;

    // Owner of the shared level-4 interrupt line
    typedef enum logic [1:0] {
        OWNER_IDLE,
        OWNER_CDIC,
        OWNER_MPEG
    } irq_owner_e;

    // Video chip RAM below and above the peripheral hole
    localparam logic [ADDR_W-1:0] VIDEO_LOW_END    = 24'h27ffff;
    localparam logic [ADDR_W-1:0] VIDEO_HIGH_START = 24'h400000;

    // Peripheral pages as upper address bytes
    localparam logic [7:0] CDIC_PAGE  = 8'h30;
    localparam logic [7:0] SLAVE_PAGE = 8'h31;
    localparam logic [7:0] NVRAM_PAGE = 8'h32;

    // Digital video cartridge windows
    localparam logic [ADDR_W-1:0] MPEG_BASE         = 24'he00000;  // 256 KB
    localparam logic [ADDR_W-1:0] DVC_ROM_BASE      = 24'he40000;  // 256 KB
    localparam logic [ADDR_W-1:0] DVC_RAM_MPEG_BASE = 24'he80000;  // 512 KB
    localparam logic [ADDR_W-1:0] DVC_RAM_BASE      = 24'hd00000;  // 1 MB

    // Auto-play boot ROM
    localparam logic [ADDR_W-1:0] ROM_BASE = 24'hf00000;
    localparam logic [ADDR_W-1:0] ROM_LAST = 24'hf00068;

    // Unmapped regions with exclusive end addresses
    localparam logic [ADDR_W-1:0] ERR_AREA1_START = 24'h080000;
    localparam logic [ADDR_W-1:0] ERR_AREA1_END   = 24'h200000;
    localparam logic [ADDR_W-1:0] ERR_AREA2_START = 24'h500000;
    localparam logic [ADDR_W-1:0] ERR_AREA2_END   = 24'hd00000;
    localparam logic [ADDR_W-1:0] ERR_ABOVE_ROM   = 24'hf10000;

    localparam int    ROM_DEPTH   = 64;
    localparam int    ROM_INDEX_W = 6;
    localparam string ROM_FILE    = "hdl/boot_rom.mem";

endpackage

`default_nettype wire
